// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsq_store_top
FILELIST  ?= lsq_store_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, decide pass/fail from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "test FAILED"; exit 1; \
	else \
	  echo "test PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/lsq_pkg.sv
package lsq_pkg;

  // store address and data
  localparam int addr_w = 32;
  localparam int data_w = 64;

  // rotated data spans three 4-byte banks
  localparam int line_data_w = 96;

  // data cache banks, bank index is addr[6:2]
  localparam int bank_cnt = 32;
  localparam int bank_w = 5;

  // store queue geometry
  localparam int sq_depth = 16;
  localparam int sq_ptr_w = 4;
  localparam int sq_cnt_w = sq_ptr_w + 1;

  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } size_e;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    size_e             size;
    logic [data_w-1:0] data;
  } store_entry_t;

endpackage

// File: logic/lsq_store_top.sv
`timescale 1ns/1ns

module lsq_store_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              flush,
  input  logic                              enq_en,
  input  logic [lsq_pkg::addr_w-1:0]        enq_addr,
  input  lsq_pkg::size_e                    enq_size,
  input  logic [lsq_pkg::data_w-1:0]        enq_data,
  input  logic                              commit_en,
  input  logic                              st_stall,
  input  logic                              agu_hold,
  output logic                              sq_full,
  output logic                              st0_en,
  output logic [lsq_pkg::addr_w-1:0]        st0_addr,
  output logic [lsq_pkg::bank_w-1:0]        st0_bgn_bank,
  output logic [lsq_pkg::bank_w-1:0]        st0_end_bank,
  output logic [3:0]                        st0_bgn_ben,
  output logic [3:0]                        st0_end_ben,
  output logic [lsq_pkg::line_data_w-1:0]   st0_data,
  output logic                              st1_en,
  output logic [lsq_pkg::addr_w-1:0]        st1_addr,
  output logic [lsq_pkg::bank_w-1:0]        st1_bgn_bank,
  output logic [lsq_pkg::bank_w-1:0]        st1_end_bank,
  output logic [3:0]                        st1_bgn_ben,
  output logic [3:0]                        st1_end_ben,
  output logic [lsq_pkg::line_data_w-1:0]   st1_data
);

  import lsq_pkg::*;

  store_entry_t        enq_entry;
  logic                issue0;
  logic                issue1;
  logic [bank_cnt-1:0] mask0;
  logic [bank_cnt-1:0] mask1;

  sq_head_if u_sq_head_if ();

  assign enq_entry = '{addr: enq_addr, size: enq_size, data: enq_data};

  store_queue u_store_queue (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .enq_en    (enq_en),
    .enq_entry (enq_entry),
    .commit_en (commit_en),
    .sq_full   (sq_full),
    .head      (u_sq_head_if.queue)
  );

  store_issue u_store_issue (
    .clk      (clk),
    .reset    (reset),
    .st_stall (st_stall),
    .agu_hold (agu_hold),
    .head     (u_sq_head_if.issue),
    .issue0   (issue0),
    .issue1   (issue1),
    .mask0    (mask0),
    .mask1    (mask1)
  );

  // port 0 always takes the older store
  store_lane u_lane0 (
    .clk         (clk),
    .reset       (reset),
    .entry       (u_sq_head_if.head0),
    .issue       (issue0),
    .bank_mask   (mask0),
    .st_en       (st0_en),
    .st_addr     (st0_addr),
    .st_bgn_bank (st0_bgn_bank),
    .st_end_bank (st0_end_bank),
    .st_bgn_ben  (st0_bgn_ben),
    .st_end_ben  (st0_end_ben),
    .st_data     (st0_data)
  );

  store_lane u_lane1 (
    .clk         (clk),
    .reset       (reset),
    .entry       (u_sq_head_if.head1),
    .issue       (issue1),
    .bank_mask   (mask1),
    .st_en       (st1_en),
    .st_addr     (st1_addr),
    .st_bgn_bank (st1_bgn_bank),
    .st_end_bank (st1_end_bank),
    .st_bgn_ben  (st1_bgn_ben),
    .st_end_ben  (st1_end_ben),
    .st_data     (st1_data)
  );

endmodule

// File: logic/sq_head_if.sv
`timescale 1ns/1ns

interface sq_head_if;

  // two oldest entries of the store queue
  lsq_pkg::store_entry_t head0;
  logic                  head0_ok;
  lsq_pkg::store_entry_t head1;
  logic                  head1_ok;

  // entries removed at this edge, 0 to 2
  logic [1:0] pop;

  modport queue (
    output head0, head0_ok, head1, head1_ok,
    input  pop
  );

  modport issue (
    input  head0, head0_ok, head1, head1_ok,
    output pop
  );

endinterface

// File: logic/store_issue.sv
`timescale 1ns/1ns

module store_issue (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         st_stall,
  input  logic                         agu_hold,
  sq_head_if.issue                     head,
  output logic                         issue0,
  output logic                         issue1,
  input  logic [lsq_pkg::bank_cnt-1:0] mask0,
  input  logic [lsq_pkg::bank_cnt-1:0] mask1
);

  import lsq_pkg::*;

  logic                st_stall_q;
  logic [bank_cnt-1:0] overlap;

  // cache stall acts one cycle late
  always_ff @(posedge clk) begin
    if (reset) begin
      st_stall_q <= 1'b0;
    end else begin
      st_stall_q <= st_stall;
    end
  end

  assign overlap = mask0 & mask1;

  assign issue0 = head.head0_ok && !agu_hold && !st_stall_q;

  // second port needs disjoint banks
  assign issue1 = issue0 && head.head1_ok && (overlap == '0);

  assign head.pop = 2'(issue0) + 2'(issue1);

  a_issue1_pair: assert property (
    @(posedge clk) disable iff (reset)
    issue1 |-> issue0
  );

endmodule

// File: logic/store_lane.sv
`timescale 1ns/1ns

module store_lane (
  input  logic                              clk,
  input  logic                              reset,
  input  lsq_pkg::store_entry_t             entry,
  input  logic                              issue,
  output logic [lsq_pkg::bank_cnt-1:0]      bank_mask,
  output logic                              st_en,
  output logic [lsq_pkg::addr_w-1:0]        st_addr,
  output logic [lsq_pkg::bank_w-1:0]        st_bgn_bank,
  output logic [lsq_pkg::bank_w-1:0]        st_end_bank,
  output logic [3:0]                        st_bgn_ben,
  output logic [3:0]                        st_end_ben,
  output logic [lsq_pkg::line_data_w-1:0]   st_data
);

  import lsq_pkg::*;

  logic [6:0]             span_bytes;
  logic [7:0]             size_ones;
  logic [6:0]             last_byte;
  logic [bank_w-1:0]      bgn_bank;
  logic [bank_w-1:0]      end_bank;
  logic [bank_w-1:0]      bank_span;
  logic [2:0]             span_mask;
  logic [2*bank_cnt-1:0]  mask_wide;
  logic [11:0]            ben_line;
  logic [3:0]             end_ben;
  logic [line_data_w-1:0] data_rot;

  always_comb begin
    case (entry.size)
      sz_byte: begin
        span_bytes = 7'd0;
        size_ones  = 8'h01;
      end
      sz_half: begin
        span_bytes = 7'd1;
        size_ones  = 8'h03;
      end
      sz_word: begin
        span_bytes = 7'd3;
        size_ones  = 8'h0f;
      end
      default: begin
        span_bytes = 7'd7;
        size_ones  = 8'hff;
      end
    endcase
  end

  // last byte wraps inside the 128-byte bank row
  assign bgn_bank  = entry.addr[6:2];
  assign last_byte = entry.addr[6:0] + span_bytes;
  assign end_bank  = last_byte[6:2];
  assign bank_span = end_bank - bgn_bank;

  assign span_mask = (bank_span == 5'd0) ? 3'b001 :
                     (bank_span == 5'd1) ? 3'b011 : 3'b111;

  // rotate over 32 banks
  assign mask_wide = {{(2*bank_cnt-3){1'b0}}, span_mask} << bgn_bank;
  assign bank_mask = mask_wide[bank_cnt-1:0] | mask_wide[2*bank_cnt-1:bank_cnt];

  assign ben_line = {4'b0000, size_ones} << entry.addr[1:0];

  always_comb begin
    case (bank_span)
      5'd0:    end_ben = ben_line[3:0];
      5'd1:    end_ben = ben_line[7:4];
      default: end_ben = ben_line[11:8];
    endcase
  end

  // byte lane alignment
  assign data_rot = {{(line_data_w-data_w){1'b0}}, entry.data} << {entry.addr[1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (reset) begin
      st_en <= 1'b0;
    end else begin
      st_en <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      st_addr     <= entry.addr;
      st_bgn_bank <= bgn_bank;
      st_end_bank <= end_bank;
      st_bgn_ben  <= ben_line[3:0];
      st_end_ben  <= end_ben;
      st_data     <= data_rot;
    end
  end

  a_mask_span: assert property (
    @(posedge clk) disable iff (reset)
    issue |-> ($countones(bank_mask) >= 1 && $countones(bank_mask) <= 3)
  );

endmodule

// File: logic/store_queue.sv
`timescale 1ns/1ns

module store_queue (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  enq_en,
  input  lsq_pkg::store_entry_t enq_entry,
  input  logic                  commit_en,
  output logic                  sq_full,
  sq_head_if.queue              head
);

  import lsq_pkg::*;

  store_entry_t mem [sq_depth];

  logic [sq_ptr_w-1:0] head_ptr;
  logic [sq_ptr_w-1:0] head1_ptr;
  logic [sq_ptr_w-1:0] tail_ptr;
  logic [sq_ptr_w-1:0] cmt_ptr;
  logic [sq_ptr_w-1:0] cmt_ptr_nxt;
  logic [sq_cnt_w-1:0] count;
  logic [sq_cnt_w-1:0] cmt_cnt;
  logic [sq_cnt_w-1:0] cmt_cnt_nxt;
  logic [sq_cnt_w-1:0] pop_cnt;
  logic                do_enq;

  // enqueue is lost under flush
  assign do_enq = enq_en && !flush;
  assign pop_cnt = sq_cnt_w'(head.pop);

  // commit lands before the flush
  assign cmt_ptr_nxt = cmt_ptr + sq_ptr_w'(commit_en);
  assign cmt_cnt_nxt = cmt_cnt + sq_cnt_w'(commit_en) - pop_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      cmt_ptr  <= '0;
      count    <= '0;
      cmt_cnt  <= '0;
    end else begin
      head_ptr <= head_ptr + sq_ptr_w'(head.pop);
      cmt_ptr  <= cmt_ptr_nxt;
      cmt_cnt  <= cmt_cnt_nxt;
      if (flush) begin
        // uncommitted tail is discarded
        tail_ptr <= cmt_ptr_nxt;
        count    <= cmt_cnt_nxt;
      end else begin
        tail_ptr <= tail_ptr + sq_ptr_w'(do_enq);
        count    <= count + sq_cnt_w'(do_enq) - pop_cnt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[tail_ptr] <= enq_entry;
    end
  end

  assign head1_ptr = head_ptr + sq_ptr_w'(1);

  assign head.head0    = mem[head_ptr];
  assign head.head1    = mem[head1_ptr];
  assign head.head0_ok = cmt_cnt >= sq_cnt_w'(1);
  assign head.head1_ok = cmt_cnt >= sq_cnt_w'(2);

  assign sq_full = count == sq_cnt_w'(sq_depth);

  a_no_enq_full: assert property (
    @(posedge clk) disable iff (reset)
    enq_en |-> !sq_full
  );

  // only entries already in the queue can commit
  a_cmt_in_range: assert property (
    @(posedge clk) disable iff (reset)
    commit_en |-> cmt_cnt < count
  );

  a_pop_committed: assert property (
    @(posedge clk) disable iff (reset)
    pop_cnt <= cmt_cnt
  );

endmodule

// File: lsq_store_top.f
logic/lsq_pkg.sv
logic/sq_head_if.sv
logic/store_queue.sv
logic/store_lane.sv
logic/store_issue.sv
logic/lsq_store_top.sv
verif/tb_lsq_store_top.sv

// File: verif/tb_lsq_store_top.sv
`timescale 1ns/1ns

module tb_lsq_store_top;

  import lsq_pkg::*;

  localparam int drain_limit = 200;

  logic                   clk;
  logic                   reset;
  logic                   flush;
  logic                   enq_en;
  logic [addr_w-1:0]      enq_addr;
  size_e                  enq_size;
  logic [data_w-1:0]      enq_data;
  logic                   commit_en;
  logic                   st_stall;
  logic                   agu_hold;
  logic                   sq_full;
  logic                   st0_en;
  logic [addr_w-1:0]      st0_addr;
  logic [bank_w-1:0]      st0_bgn_bank;
  logic [bank_w-1:0]      st0_end_bank;
  logic [3:0]             st0_bgn_ben;
  logic [3:0]             st0_end_ben;
  logic [line_data_w-1:0] st0_data;
  logic                   st1_en;
  logic [addr_w-1:0]      st1_addr;
  logic [bank_w-1:0]      st1_bgn_bank;
  logic [bank_w-1:0]      st1_end_bank;
  logic [3:0]             st1_bgn_ben;
  logic [3:0]             st1_end_ben;
  logic [line_data_w-1:0] st1_data;

  integer       seed;
  int           mismatches;
  int           failures;
  int           timeouts;
  int           issued;
  int           n_cmt;
  string        test_name;
  logic         stall_q1;
  logic         stall_q2;
  logic         hold_q;
  // reference queue in program order, committed entries first
  store_entry_t pend [$];

  lsq_store_top u_lsq_store_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [95:0] expected,
                           input logic [95:0] actual);
    assert (expected === actual) else begin
      mismatches++;
      $display("Mismatch %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      failures++;
      $display("error in %s: %s", test_name, what);
    end
  endtask

  // walk the bytes of the store one by one
  task automatic expect_banks(input store_entry_t s, output logic [bank_w-1:0] bgn,
                              output logic [bank_w-1:0] last, output logic [3:0] bben,
                              output logic [3:0] eben, output logic [bank_cnt-1:0] mask);
    logic [6:0] a;
    int         nbytes;
    int         k;
    nbytes = 1 << int'(s.size);
    bgn = s.addr[6:2];
    a = s.addr[6:0] + 7'(nbytes - 1);
    last = a[6:2];
    bben = '0;
    eben = '0;
    mask = '0;
    for (k = 0; k < nbytes; k++) begin
      a = s.addr[6:0] + 7'(k);
      mask[a[6:2]] = 1'b1;
      if (a[6:2] == bgn) bben[a[1:0]] = 1'b1;
      if (a[6:2] == last) eben[a[1:0]] = 1'b1;
    end
  endtask

  function automatic logic [line_data_w-1:0] expect_data(input store_entry_t s);
    logic [line_data_w-1:0] d;
    int                     k;
    d = '0;
    for (k = 0; k < 8; k++) begin
      d[8*(k + int'(s.addr[1:0])) +: 8] = s.data[8*k +: 8];
    end
    return d;
  endfunction

  task automatic check_port(input string port, input store_entry_t s,
                            input logic [addr_w-1:0] addr, input logic [bank_w-1:0] bgn,
                            input logic [bank_w-1:0] last, input logic [3:0] bben,
                            input logic [3:0] eben, input logic [line_data_w-1:0] data,
                            output logic [bank_cnt-1:0] mask);
    logic [bank_w-1:0] x_bgn;
    logic [bank_w-1:0] x_last;
    logic [3:0]        x_bben;
    logic [3:0]        x_eben;
    expect_banks(s, x_bgn, x_last, x_bben, x_eben, mask);
    check_val({port, "_addr"}, 96'(s.addr), 96'(addr));
    check_val({port, "_bgn_bank"}, 96'(x_bgn), 96'(bgn));
    check_val({port, "_end_bank"}, 96'(x_last), 96'(last));
    check_val({port, "_bgn_ben"}, 96'(x_bben), 96'(bben));
    check_val({port, "_end_ben"}, 96'(x_eben), 96'(eben));
    check_val({port, "_data"}, expect_data(s), data);
  endtask

  // outputs seen here were registered at the previous edge
  task automatic observe();
    store_entry_t        e;
    logic [bank_cnt-1:0] m0;
    logic [bank_cnt-1:0] m1;
    m0 = '0;
    m1 = '0;
    if (reset) begin
      stall_q1 = 1'b0;
      stall_q2 = 1'b0;
      hold_q = 1'b0;
      return;
    end
    if (st1_en) check_true(st0_en, "st1 fired without st0");
    if (st0_en) begin
      check_true(!hold_q && !stall_q2, "store issued while stall or hold was active");
      if (n_cmt > 0) begin
        e = pend.pop_front();
        n_cmt--;
        issued++;
        check_port("st0", e, st0_addr, st0_bgn_bank, st0_end_bank, st0_bgn_ben,
                   st0_end_ben, st0_data, m0);
      end else begin
        check_true(1'b0, "st0 issued with no committed store left");
      end
    end
    if (st0_en && st1_en) begin
      if (n_cmt > 0) begin
        e = pend.pop_front();
        n_cmt--;
        issued++;
        check_port("st1", e, st1_addr, st1_bgn_bank, st1_end_bank, st1_bgn_ben,
                   st1_end_ben, st1_data, m1);
        check_true((m0 & m1) == '0, "st0 and st1 issued to a shared bank");
      end else begin
        check_true(1'b0, "st1 issued with no committed store left");
      end
    end
    check_val("sq_full", 96'(pend.size() == sq_depth), 96'(sq_full));
    // commit first, then flush, then enqueue
    if (commit_en) n_cmt++;
    if (flush) begin
      while (pend.size() > n_cmt) void'(pend.pop_back());
    end
    if (enq_en && !flush) pend.push_back('{addr: enq_addr, size: enq_size, data: enq_data});
    stall_q2 = stall_q1;
    stall_q1 = st_stall;
    hold_q = agu_hold;
  endtask

  task automatic tick();
    @(posedge clk);
    observe();
  endtask

  // never overfill the queue or commit past the last entry
  task automatic drive(input logic want_enq, input logic want_commit, input logic want_flush,
                       input logic stall, input logic hold);
    logic [31:0] r;
    r = $random(seed);
    enq_en    <= want_enq && (pend.size() < sq_depth);
    enq_addr  <= $random(seed);
    enq_size  <= size_e'(r[1:0]);
    enq_data  <= {$random(seed), $random(seed)};
    commit_en <= want_commit && (pend.size() > n_cmt);
    flush     <= want_flush;
    st_stall  <= stall;
    agu_hold  <= hold;
  endtask

  task automatic commit_all();
    int k;
    for (k = 0; k < sq_depth + 2; k++) begin
      tick();
      drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    tick();
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    while (n_cmt != 0 && cycles < drain_limit) begin
      tick();
      drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      cycles++;
    end
    if (n_cmt != 0) begin
      timeouts++;
      $display("timeout in %s: %0d committed stores never issued", test_name, n_cmt);
    end
  endtask

  task automatic wait_full(input logic level, input logic stall);
    int cycles;
    cycles = 0;
    while (sq_full !== level && cycles < drain_limit) begin
      tick();
      drive(1'b0, 1'b0, 1'b0, stall, 1'b0);
      cycles++;
    end
    if (sq_full !== level) begin
      timeouts++;
      $display("timeout in %s: sq_full never reached %0b", test_name, level);
    end
  endtask

  initial begin
    logic [31:0] r;
    int          i;
    int          base;
    seed = 32'hd6c2647f;
    mismatches = 0;
    failures = 0;
    timeouts = 0;
    issued = 0;
    n_cmt = 0;
    test_name = "reset";
    reset <= 1'b1;
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (2) tick();
    reset <= 1'b0;

    test_name = "random";
    for (i = 0; i < 400; i++) begin
      tick();
      r = $random(seed);
      drive(r[1:0] != 2'b00, r[3:2] != 2'b00, r[9:4] == 6'd0, r[13:11] == 3'd0,
            r[16:14] == 3'd0);
    end
    commit_all();
    wait_drain();

    // cache stall then AGU hold alone
    test_name = "stall";
    for (i = 0; i < 60; i++) begin
      tick();
      r = $random(seed);
      drive(r[0], r[1], 1'b0, i < 40, r[2] || i >= 40);
    end
    commit_all();
    wait_drain();

    test_name = "flush";
    base = issued;
    for (i = 0; i < 8; i++) begin
      tick();
      drive(i < 6, i >= 6, 1'b0, 1'b1, 1'b0);
    end
    // commit and enqueue together with the flush
    tick();
    drive(1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
    wait_drain();
    check_val("flush_drained", 96'(3), 96'(issued - base));

    test_name = "full";
    for (i = 0; i < sq_depth; i++) begin
      tick();
      drive(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    end
    wait_full(1'b1, 1'b1);
    commit_all();
    wait_drain();
    wait_full(1'b0, 1'b0);

    $display("errors: %0d mismatches, %0d failed checks, %0d timeouts, %0d stores issued",
             mismatches, failures, timeouts, issued);
    if (mismatches + failures + timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
